/* rtl/lcd_pkg.sv */
// lcd controller package with opcodes, decoder states, register map and bus timing
package lcd_pkg;

  // panel command opcodes, ILI9341 style
  typedef enum logic [7:0] {
    SCAN    = 8'h36,
    SC_EC   = 8'h2A,
    SP_EP   = 8'h2B,
    W_COLOR = 8'h2C,
    R_COLOR = 8'h2E,
    ID1     = 8'hDA,
    ID2     = 8'hDB,
    ID3     = 8'hDC
  } lcd_op_e;

  typedef enum logic [4:0] {
    IDLE,
    READ_ID,
    SCAN_INST, SCAN_DATA,
    SC_INST1, SC_DATA1, SC_INST2, SC_DATA2,
    EC_INST1, EC_DATA1, EC_INST2, EC_DATA2,
    SP_INST1, SP_DATA1, SP_INST2, SP_DATA2,
    EP_INST1, EP_DATA1, EP_INST2, EP_DATA2,
    COLOR_INST, COLOR_DATA,
    READ_COLOR
  } lcd_id_state_e;

  // function field of SC_EC and SP_EP
  localparam logic [7:0] FN_START = 8'h00;
  localparam logic [7:0] FN_END   = 8'h02;

  // processor register map, byte addresses
  localparam logic [31:0] LCD_CMD_ADDR   = 32'h0000_0000;
  localparam logic [31:0] LCD_STAT_ADDR  = 32'h0000_0004;
  localparam logic [31:0] LCD_RDATA_ADDR = 32'h0000_0008;

  // panel strobe timing in pclk cycles
  localparam int BUS_CNT_W = 4;
  localparam logic [BUS_CNT_W-1:0] WR_LOW_CYC  = 4'd2;
  localparam logic [BUS_CNT_W-1:0] WR_HIGH_CYC = 4'd2;
  localparam logic [BUS_CNT_W-1:0] RD_LOW_CYC  = 4'd3;
  localparam logic [BUS_CNT_W-1:0] RD_HIGH_CYC = 4'd2;

endpackage

/* rtl/lcd_regs.sv */
// lcd register block holding one pending command word, status and read-back data
`timescale 1ns/10ps
module lcd_regs (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        cpu_we_i,
  input  logic        cpu_re_i,
  input  logic [31:0] cpu_addr_i,
  input  logic [31:0] cpu_wdata_i,
  output logic [31:0] cpu_rdata_o,
  input  logic        write_ok_i,
  output logic        write_lcd_o,
  output logic [31:0] lcd_cmd_o,
  input  logic        rdata_valid_i,
  input  logic [15:0] rdata_i
);
  import lcd_pkg::*;

  logic [31:0] cmd_q;
  logic        pending_q;
  logic [1:0]  hold_q;
  logic        ovf_q;
  logic        rd_valid_q;
  logic [15:0] rd_word_q;
  logic        cmd_wr;
  logic        rdata_rd;
  logic [31:0] stat_word;

  assign cmd_wr   = cpu_we_i && (cpu_addr_i == LCD_CMD_ADDR);
  assign rdata_rd = cpu_re_i && (cpu_addr_i == LCD_RDATA_ADDR);

  // decoder needs two cycles before write_ok reflects a new word
  assign write_lcd_o = pending_q && write_ok_i && (hold_q == 2'd0);
  assign lcd_cmd_o   = cmd_q;

  // bit 0 stays set until write_ok has had time to fall
  assign stat_word = {28'd0, ovf_q, rd_valid_q, write_ok_i, pending_q || (hold_q != 2'd0)};

  always_ff @(posedge pclk) begin
    if (cmd_wr && !pending_q) begin
      cmd_q <= cpu_wdata_i;
    end
    if (rdata_valid_i) begin
      rd_word_q <= rdata_i;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      pending_q   <= 1'b0;
      hold_q      <= 2'd0;
      ovf_q       <= 1'b0;
      rd_valid_q  <= 1'b0;
      cpu_rdata_o <= '0;
    end else begin
      if (write_lcd_o) begin
        pending_q <= 1'b0;
        hold_q    <= 2'd2;
      end else if (hold_q != 2'd0) begin
        hold_q <= hold_q - 1'b1;
      end
      if (rdata_rd) begin
        ovf_q <= 1'b0;
      end
      // slot full, new word is dropped
      if (cmd_wr) begin
        if (pending_q) begin
          ovf_q <= 1'b1;
        end else begin
          pending_q <= 1'b1;
        end
      end
      if (rdata_valid_i) begin
        rd_valid_q <= 1'b1;
      end else if (rdata_rd) begin
        rd_valid_q <= 1'b0;
      end
      if (cpu_re_i) begin
        case (cpu_addr_i)
          LCD_CMD_ADDR:   cpu_rdata_o <= cmd_q;
          LCD_STAT_ADDR:  cpu_rdata_o <= stat_word;
          LCD_RDATA_ADDR: cpu_rdata_o <= {16'd0, rd_word_q};
          default:        cpu_rdata_o <= '0;
        endcase
      end
    end
  end

  // write_ok only falls two cycles after an issue, the gap hold_q covers
  a_write_ok_latency: assert property (@(posedge pclk) disable iff (!rst_n)
    $fell(write_ok_i) |-> $past(write_lcd_o, 2));

endmodule

/* rtl/lcd_id.sv */
// lcd instruction decoder expanding a command word into panel instruction and data words
`timescale 1ns/10ps
module lcd_id (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        write_lcd_i,
  input  logic [31:0] lcd_cmd_i,
  output logic        write_ok_o,
  output logic        we_o,
  output logic        wr_o,
  output logic        lcd_rs_o,
  output logic [15:0] data_o,
  input  logic        busy_i
);
  import lcd_pkg::*;

  lcd_id_state_e state, next_state, succ_state;

  logic [31:0] cmd_q;
  logic        cmd_vld;
  lcd_op_e     opcode;
  logic [7:0]  func;
  logic [15:0] param;
  logic        wr_nxt;
  logic        rs_nxt;
  logic [15:0] word_nxt;

  // command word is opcode, function, 16-bit parameter
  assign opcode = lcd_op_e'(cmd_q[31:24]);
  assign func   = cmd_q[23:16];
  assign param  = cmd_q[15:0];

  always_ff @(posedge pclk) begin
    if (write_lcd_i) begin
      cmd_q <= lcd_cmd_i;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      cmd_vld <= 1'b0;
    end else begin
      cmd_vld <= write_lcd_i;
    end
  end

  always_comb begin
    succ_state = IDLE;
    case (state)
      IDLE: begin
        if (cmd_vld) begin
          case (opcode)
            ID1, ID2, ID3: succ_state = READ_ID;
            SCAN:          succ_state = SCAN_INST;
            SC_EC: begin
              if (func == FN_START) begin
                succ_state = SC_INST1;
              end else if (func == FN_END) begin
                succ_state = EC_INST1;
              end
            end
            SP_EP: begin
              if (func == FN_START) begin
                succ_state = SP_INST1;
              end else if (func == FN_END) begin
                succ_state = EP_INST1;
              end
            end
            W_COLOR:       succ_state = COLOR_INST;
            R_COLOR:       succ_state = READ_COLOR;
            default:       succ_state = IDLE;
          endcase
        end
      end
      SCAN_INST:  succ_state = SCAN_DATA;
      SC_INST1:   succ_state = SC_DATA1;
      SC_DATA1:   succ_state = SC_INST2;
      SC_INST2:   succ_state = SC_DATA2;
      EC_INST1:   succ_state = EC_DATA1;
      EC_DATA1:   succ_state = EC_INST2;
      EC_INST2:   succ_state = EC_DATA2;
      SP_INST1:   succ_state = SP_DATA1;
      SP_DATA1:   succ_state = SP_INST2;
      SP_INST2:   succ_state = SP_DATA2;
      EP_INST1:   succ_state = EP_DATA1;
      EP_DATA1:   succ_state = EP_INST2;
      EP_INST2:   succ_state = EP_DATA2;
      COLOR_INST: succ_state = COLOR_DATA;
      default:    succ_state = IDLE;
    endcase
  end

  // every word state waits for the bus to drop busy
  assign next_state = (state != IDLE && busy_i) ? state : succ_state;

  // panel word for the state being entered
  always_comb begin
    wr_nxt   = 1'b1;
    rs_nxt   = 1'b0;
    word_nxt = {opcode, 8'h00};
    case (next_state)
      IDLE: begin
        wr_nxt   = 1'b0;
        word_nxt = '0;
      end
      READ_ID, READ_COLOR: wr_nxt = 1'b0;
      SCAN_DATA, COLOR_DATA: begin
        rs_nxt   = 1'b1;
        word_nxt = param;
      end
      SC_DATA1, EC_DATA1, SP_DATA1, EP_DATA1: begin
        rs_nxt   = 1'b1;
        word_nxt = {8'h00, param[15:8]};
      end
      SC_DATA2, EC_DATA2, SP_DATA2, EP_DATA2: begin
        rs_nxt   = 1'b1;
        word_nxt = {8'h00, param[7:0]};
      end
      SC_INST2, SP_INST2: word_nxt = {opcode, 8'h01};
      EC_INST1, EP_INST1: word_nxt = {opcode, 8'h02};
      EC_INST2, EP_INST2: word_nxt = {opcode, 8'h03};
      default: ;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state      <= IDLE;
      write_ok_o <= 1'b1;
      we_o       <= 1'b0;
      wr_o       <= 1'b0;
      lcd_rs_o   <= 1'b0;
      data_o     <= '0;
    end else begin
      state      <= next_state;
      write_ok_o <= (next_state == IDLE);
      // single strobe on entry to a word state
      we_o       <= (next_state != IDLE) && (next_state != state);
      wr_o       <= wr_nxt;
      lcd_rs_o   <= rs_nxt;
      data_o     <= word_nxt;
    end
  end

  // bus raises busy on we, so each word gets one strobe
  a_we_single: assert property (@(posedge pclk) disable iff (!rst_n)
    we_o |=> !we_o);

endmodule

/* rtl/lcd_bus.sv */
// lcd bus sequencer driving 8080-style cs, wr, rd and rs cycles and capturing read data
`timescale 1ns/10ps
module lcd_bus (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        we_i,
  input  logic        wr_i,
  input  logic        rs_i,
  input  logic [15:0] data_i,
  output logic        busy_o,
  output logic        rdata_valid_o,
  output logic [15:0] rdata_o,
  input  logic [15:0] lcd_db_i,
  output logic        lcd_cs_n_o,
  output logic        lcd_rs_o,
  output logic        lcd_wr_n_o,
  output logic        lcd_rd_n_o,
  output logic [15:0] lcd_db_o,
  output logic        lcd_db_oe_o
);
  import lcd_pkg::*;

  typedef enum logic [2:0] {
    BUS_IDLE,
    BUS_WR_LO,
    BUS_WR_HI,
    BUS_RD_LO,
    BUS_RD_HI
  } bus_phase_e;

  bus_phase_e           phase, phase_nxt;
  logic [BUS_CNT_W-1:0] cnt, cnt_nxt;
  logic                 wr_q;
  logic                 rs_q;
  logic                 rs_nxt;
  logic                 last;

  always_comb begin
    phase_nxt = phase;
    cnt_nxt   = cnt - 1'b1;
    case (phase)
      BUS_IDLE: begin
        cnt_nxt = '0;
        if (we_i) begin
          phase_nxt = BUS_WR_LO;
          cnt_nxt   = WR_LOW_CYC - 1'b1;
        end
      end
      BUS_WR_LO: if (cnt == '0) begin
        phase_nxt = BUS_WR_HI;
        cnt_nxt   = WR_HIGH_CYC - 1'b1;
      end
      BUS_WR_HI: if (cnt == '0) begin
        // reads continue with a data phase after the command write
        phase_nxt = wr_q ? BUS_IDLE : BUS_RD_LO;
        cnt_nxt   = wr_q ? '0 : RD_LOW_CYC - 1'b1;
      end
      BUS_RD_LO: if (cnt == '0) begin
        phase_nxt = BUS_RD_HI;
        cnt_nxt   = RD_HIGH_CYC - 1'b1;
      end
      default: if (cnt == '0) begin
        phase_nxt = BUS_IDLE;
        cnt_nxt   = '0;
      end
    endcase
  end

  // final high cycle of a transfer, decoder may move on here
  assign last = (cnt == '0) && ((phase == BUS_WR_HI && wr_q) || phase == BUS_RD_HI);
  assign busy_o        = (phase == BUS_IDLE) ? we_i : !last;
  assign rdata_valid_o = last && !wr_q;
  assign rs_nxt        = (phase == BUS_IDLE) ? rs_i : rs_q;

  always_ff @(posedge pclk) begin
    if (phase == BUS_IDLE && we_i) begin
      wr_q     <= wr_i;
      rs_q     <= rs_i;
      lcd_db_o <= data_i;
    end
    // sample in the last rd low cycle
    if (phase == BUS_RD_LO && cnt == '0) begin
      rdata_o <= lcd_db_i;
    end
  end

  // pins registered from the next phase so they line up with it
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      phase       <= BUS_IDLE;
      cnt         <= '0;
      lcd_cs_n_o  <= 1'b1;
      lcd_wr_n_o  <= 1'b1;
      lcd_rd_n_o  <= 1'b1;
      lcd_rs_o    <= 1'b1;
      lcd_db_oe_o <= 1'b0;
    end else begin
      phase       <= phase_nxt;
      cnt         <= cnt_nxt;
      lcd_cs_n_o  <= (phase_nxt == BUS_IDLE);
      lcd_wr_n_o  <= (phase_nxt != BUS_WR_LO);
      lcd_rd_n_o  <= (phase_nxt != BUS_RD_LO);
      lcd_db_oe_o <= (phase_nxt == BUS_WR_LO) || (phase_nxt == BUS_WR_HI);
      lcd_rs_o    <= (phase_nxt == BUS_WR_LO || phase_nxt == BUS_WR_HI) ? rs_nxt : 1'b1;
    end
  end

  // a new word only arrives once the previous transfer is over
  a_we_when_idle: assert property (@(posedge pclk) disable iff (!rst_n)
    we_i |-> (phase == BUS_IDLE));

endmodule

/* rtl/lcd_top.sv */
// lcd controller top connecting register block, instruction decoder and bus sequencer
`timescale 1ns/10ps
module lcd_top (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        cpu_we_i,
  input  logic        cpu_re_i,
  input  logic [31:0] cpu_addr_i,
  input  logic [31:0] cpu_wdata_i,
  output logic [31:0] cpu_rdata_o,
  input  logic [15:0] lcd_db_i,
  output logic        lcd_cs_n_o,
  output logic        lcd_rs_o,
  output logic        lcd_wr_n_o,
  output logic        lcd_rd_n_o,
  output logic [15:0] lcd_db_o,
  output logic        lcd_db_oe_o
);

  logic        write_ok;
  logic        write_lcd;
  logic [31:0] lcd_cmd;
  logic        rdata_valid;
  logic [15:0] rdata;
  logic        we;
  logic        wr;
  logic        word_rs;
  logic [15:0] word;
  logic        busy;

  lcd_regs u_regs (
    .pclk          (pclk),
    .rst_n         (rst_n),
    .cpu_we_i      (cpu_we_i),
    .cpu_re_i      (cpu_re_i),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_wdata_i   (cpu_wdata_i),
    .cpu_rdata_o   (cpu_rdata_o),
    .write_ok_i    (write_ok),
    .write_lcd_o   (write_lcd),
    .lcd_cmd_o     (lcd_cmd),
    .rdata_valid_i (rdata_valid),
    .rdata_i       (rdata)
  );

  lcd_id u_id (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .write_lcd_i (write_lcd),
    .lcd_cmd_i   (lcd_cmd),
    .write_ok_o  (write_ok),
    .we_o        (we),
    .wr_o        (wr),
    .lcd_rs_o    (word_rs),
    .data_o      (word),
    .busy_i      (busy)
  );

  lcd_bus u_bus (
    .pclk          (pclk),
    .rst_n         (rst_n),
    .we_i          (we),
    .wr_i          (wr),
    .rs_i          (word_rs),
    .data_i        (word),
    .busy_o        (busy),
    .rdata_valid_o (rdata_valid),
    .rdata_o       (rdata),
    .lcd_db_i      (lcd_db_i),
    .lcd_cs_n_o    (lcd_cs_n_o),
    .lcd_rs_o      (lcd_rs_o),
    .lcd_wr_n_o    (lcd_wr_n_o),
    .lcd_rd_n_o    (lcd_rd_n_o),
    .lcd_db_o      (lcd_db_o),
    .lcd_db_oe_o   (lcd_db_oe_o)
  );

endmodule

/* sim/lcd_checker.sv */
// lcd checker comparing panel pin activity and register reads against a command model
`timescale 1ns/10ps
module lcd_checker (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        cpu_re_i,
  input  logic [31:0] cpu_addr_i,
  input  logic [31:0] cpu_rdata_i,
  input  logic        pin_cs_n_i,
  input  logic        pin_rs_i,
  input  logic        pin_wr_n_i,
  input  logic        pin_rd_n_i,
  input  logic [15:0] pin_db_i,
  input  logic        pin_db_oe_i,
  input  logic        load_i,
  input  logic [31:0] cmd_i,
  input  logic [15:0] rd_value_i,
  input  logic [1:0]  flag_i,
  input  logic        done_i,
  output int          err_count_o
);
  import lcd_pkg::*;

  // entry is {read transaction, rs, word}
  logic [17:0] exp_q[$];
  logic [17:0] entry;
  logic [15:0] cur_rd_value;
  logic [1:0]  cur_flag;
  logic [31:0] last_stat;
  logic [31:0] exp_stat;
  logic        started;
  logic        wr_prev;
  logic        rd_prev;
  logic        stat_due;
  logic        rdata_due;
  int          wr_low;
  int          rd_low;
  int          reads_due;
  int          errors = 0;

  assign err_count_o = errors;

  task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("Mismatch at %0t: %s expected %h got %h", $time, sig, exp, got);
    errors++;
  endtask

  task automatic report_fail(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  // panel words that one command word should produce
  task automatic build_expected(input logic [31:0] cmd);
    logic [7:0]  op;
    logic [7:0]  fn;
    logic [7:0]  lo;
    logic [15:0] p;
    op = cmd[31:24];
    fn = cmd[23:16];
    p  = cmd[15:0];
    lo = (fn == FN_START) ? 8'h00 : 8'h02;
    case (op)
      ID1, ID2, ID3, R_COLOR: exp_q.push_back({1'b1, 1'b0, op, 8'h00});
      SCAN, W_COLOR: begin
        exp_q.push_back({1'b0, 1'b0, op, 8'h00});
        exp_q.push_back({1'b0, 1'b1, p});
      end
      SC_EC, SP_EP: begin
        if (fn == FN_START || fn == FN_END) begin
          exp_q.push_back({1'b0, 1'b0, op, lo});
          exp_q.push_back({1'b0, 1'b1, 8'h00, p[15:8]});
          exp_q.push_back({1'b0, 1'b0, op, lo + 8'h01});
          exp_q.push_back({1'b0, 1'b1, 8'h00, p[7:0]});
        end
      end
      default: ;
    endcase
  endtask

  always @(posedge pclk) begin
    if (!rst_n) begin
      exp_q.delete();
      cur_rd_value = '0;
      cur_flag     = '0;
      last_stat    = '0;
      started      = 1'b0;
      wr_prev      = 1'b1;
      rd_prev      = 1'b1;
      stat_due     = 1'b0;
      rdata_due    = 1'b0;
      wr_low       = 0;
      rd_low       = 0;
      reads_due    = 0;
    end else begin
      // read data shows up one cycle after the read strobe
      if (stat_due) begin
        last_stat = cpu_rdata_i;
      end
      if (rdata_due && cpu_rdata_i !== {16'h0000, cur_rd_value}) begin
        report_mismatch("cpu_rdata", {16'h0000, cur_rd_value}, cpu_rdata_i);
      end
      stat_due  = cpu_re_i && (cpu_addr_i == LCD_STAT_ADDR);
      rdata_due = cpu_re_i && (cpu_addr_i == LCD_RDATA_ADDR) && cur_flag[0];

      if (!started && (pin_cs_n_i !== 1'b1 || pin_wr_n_i !== 1'b1 || pin_rd_n_i !== 1'b1)) begin
        report_fail("panel strobes active before the first command");
      end
      if ((!pin_wr_n_i || !pin_rd_n_i) && pin_cs_n_i) begin
        report_fail("wr or rd strobe low while cs is high");
      end
      if (!pin_wr_n_i && !pin_db_oe_i) begin
        report_fail("data bus not driven during a write strobe");
      end
      if (!pin_rd_n_i && pin_db_oe_i) begin
        report_fail("data bus still driven during a read strobe");
      end
      if (!pin_wr_n_i) begin
        wr_low++;
      end
      if (!pin_rd_n_i) begin
        rd_low++;
      end

      // wr_n rising edge, the word is still on the pins
      if (!wr_prev && pin_wr_n_i) begin
        if (wr_low != WR_LOW_CYC) begin
          report_mismatch("wr_n low cycles", 32'(WR_LOW_CYC), wr_low);
        end
        wr_low = 0;
        if (exp_q.size() == 0) begin
          report_fail($sformatf("unexpected panel write of %h", pin_db_i));
        end else begin
          entry = exp_q.pop_front();
          if (pin_rs_i !== entry[16]) begin
            report_mismatch("lcd_rs", 32'(entry[16]), 32'(pin_rs_i));
          end
          if (pin_db_i !== entry[15:0]) begin
            report_mismatch("lcd_db", 32'(entry[15:0]), 32'(pin_db_i));
          end
          if (entry[17]) begin
            reads_due++;
          end
        end
      end
      if (!rd_prev && pin_rd_n_i) begin
        if (rd_low != RD_LOW_CYC) begin
          report_mismatch("rd_n low cycles", 32'(RD_LOW_CYC), rd_low);
        end
        rd_low = 0;
        if (reads_due == 0) begin
          report_fail("unexpected read strobe on the panel");
        end else begin
          reads_due--;
        end
      end
      wr_prev = pin_wr_n_i;
      rd_prev = pin_rd_n_i;

      if (load_i) begin
        started      = 1'b1;
        cur_rd_value = rd_value_i;
        cur_flag     = flag_i;
        exp_q.delete();
        build_expected(cmd_i);
      end
      if (done_i) begin
        exp_stat = {28'd0, cur_flag[1], cur_flag[0], 1'b1, 1'b0};
        if (last_stat !== exp_stat) begin
          report_mismatch("status", exp_stat, last_stat);
        end
        if (exp_q.size() != 0) begin
          report_fail($sformatf("%0d expected panel words never appeared", exp_q.size()));
        end
        if (reads_due != 0) begin
          report_fail("read phase missing after a read command");
        end
      end
    end
  end

endmodule

/* sim/tb_lcd_top.sv */
// testbench for the lcd controller with pattern-driven cpu accesses and a panel read model
`timescale 1ns/10ps
module tb_lcd_top;
  import lcd_pkg::*;

  localparam int POLL_LIMIT = 200;

  logic        pclk;
  logic        rst_n;
  logic        cpu_we_i;
  logic        cpu_re_i;
  logic [31:0] cpu_addr_i;
  logic [31:0] cpu_wdata_i;
  logic [31:0] cpu_rdata_o;
  logic [15:0] lcd_db_i;
  logic        lcd_cs_n_o;
  logic        lcd_rs_o;
  logic        lcd_wr_n_o;
  logic        lcd_rd_n_o;
  logic [15:0] lcd_db_o;
  logic        lcd_db_oe_o;

  logic        load;
  logic        done;
  logic [31:0] exp_cmd;
  logic [15:0] rd_value;
  logic [1:0]  exp_flag;
  logic [15:0] noise;
  integer      seed;
  integer      fd;
  logic [8*128-1:0] line;
  logic [31:0] pat_cmd;
  logic [15:0] pat_rd;
  logic [3:0]  pat_flag;
  int          chk_errors;
  int          tb_errors;
  int          n_cmds;
  bit          timed_out;

  lcd_top uut (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .cpu_we_i    (cpu_we_i),
    .cpu_re_i    (cpu_re_i),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_wdata_i (cpu_wdata_i),
    .cpu_rdata_o (cpu_rdata_o),
    .lcd_db_i    (lcd_db_i),
    .lcd_cs_n_o  (lcd_cs_n_o),
    .lcd_rs_o    (lcd_rs_o),
    .lcd_wr_n_o  (lcd_wr_n_o),
    .lcd_rd_n_o  (lcd_rd_n_o),
    .lcd_db_o    (lcd_db_o),
    .lcd_db_oe_o (lcd_db_oe_o)
  );

  lcd_checker u_checker (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .cpu_re_i    (cpu_re_i),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_rdata_i (cpu_rdata_o),
    .pin_cs_n_i  (lcd_cs_n_o),
    .pin_rs_i    (lcd_rs_o),
    .pin_wr_n_i  (lcd_wr_n_o),
    .pin_rd_n_i  (lcd_rd_n_o),
    .pin_db_i    (lcd_db_o),
    .pin_db_oe_i (lcd_db_oe_o),
    .load_i      (load),
    .cmd_i       (exp_cmd),
    .rd_value_i  (rd_value),
    .flag_i      (exp_flag),
    .done_i      (done),
    .err_count_o (chk_errors)
  );

  always #50 pclk = ~pclk;

  // panel drives the read value only while rd is low, junk otherwise
  assign lcd_db_i = (lcd_rd_n_o === 1'b0) ? rd_value : noise;

  always begin
    @(posedge pclk);
    #5;
    noise = 16'($random(seed));
  end

  task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
    cpu_we_i    = 1'b1;
    cpu_addr_i  = addr;
    cpu_wdata_i = data;
    @(posedge pclk);
    #5;
    cpu_we_i = 1'b0;
  endtask

  task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data);
    cpu_re_i   = 1'b1;
    cpu_addr_i = addr;
    @(posedge pclk);
    #5;
    cpu_re_i = 1'b0;
    data     = cpu_rdata_o;
  endtask

  task automatic pulse_signal(ref logic sig);
    sig = 1'b1;
    @(posedge pclk);
    #5;
    sig = 1'b0;
  endtask

  // idle means nothing pending and write_ok high
  task automatic wait_idle();
    logic [31:0] stat;
    int          polls;
    polls = 0;
    cpu_read(LCD_STAT_ADDR, stat);
    while (stat[1:0] !== 2'b10 && polls < POLL_LIMIT) begin
      cpu_read(LCD_STAT_ADDR, stat);
      polls++;
    end
    if (stat[1:0] !== 2'b10) begin
      $display("Timeout at %0t: status did not return to idle within %0d polls",
               $time, POLL_LIMIT);
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_command(input logic [31:0] cmd, input logic [15:0] rdv,
                             input logic [1:0] flg);
    logic [31:0] rdata;
    exp_cmd  = cmd;
    rd_value = rdv;
    exp_flag = flg;
    pulse_signal(load);
    cpu_write(LCD_CMD_ADDR, cmd);
    // second word lands while the slot is still pending
    if (flg[1]) begin
      cpu_write(LCD_CMD_ADDR, cmd ^ 32'h0000_FFFF);
    end
    wait_idle();
    if (!timed_out) begin
      if (flg != 2'b00) begin
        cpu_read(LCD_RDATA_ADDR, rdata);
      end
      @(posedge pclk);
      #5;
      pulse_signal(done);
    end
  endtask

  initial begin
    pclk        = 1'b0;
    rst_n       = 1'b0;
    cpu_we_i    = 1'b0;
    cpu_re_i    = 1'b0;
    cpu_addr_i  = '0;
    cpu_wdata_i = '0;
    load        = 1'b0;
    done        = 1'b0;
    exp_cmd     = '0;
    rd_value    = '0;
    exp_flag    = '0;
    noise       = '0;
    seed        = 32'ha812;
    tb_errors   = 0;
    n_cmds      = 0;
    timed_out   = 1'b0;
    repeat (16) @(posedge pclk);
    #5;
    rst_n = 1'b1;
    @(posedge pclk);
    #5;
    // status right after reset, checker expects idle
    wait_idle();
    if (!timed_out) begin
      @(posedge pclk);
      #5;
      pulse_signal(done);
    end
    fd = $fopen("sim/lcd_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file sim/lcd_patterns.txt");
      tb_errors++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          if ($sscanf(line, "%h %h %h", pat_cmd, pat_rd, pat_flag) == 3) begin
            run_command(pat_cmd, pat_rd, pat_flag[1:0]);
            n_cmds++;
          end
        end
      end
      $fclose(fd);
      if (n_cmds == 0) begin
        $display("No commands found in the pattern file");
        tb_errors++;
      end
    end
    repeat (4) @(posedge pclk);
    $display("Error counts: checker %0d, testbench %0d, commands run %0d",
             chk_errors, tb_errors, n_cmds);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim/lcd_patterns.txt */
# lcd controller stimulus, one command per line
# columns: command word (hex), panel read value (hex), flags (bit0 read data, bit1 overflow)
36000048 0000 0
2C00F800 0000 0
2A000123 0000 0
2A0200EF 0000 0
2B000000 0000 0
2B02013F 0000 0
DA000000 0093 1
DB000000 1234 1
DC000000 9341 1
2E000000 A5C3 1
2C0007E0 0000 2
2A01ABCD 0000 0
55001234 0000 0
2E000000 5A3C 3
2B00FFFF 0000 0
36000000 0000 0
2C00001F 0000 0
2A02FFFF 0000 0

/* files.f */
rtl/lcd_pkg.sv
rtl/lcd_regs.sv
rtl/lcd_id.sv
rtl/lcd_bus.sv
rtl/lcd_top.sv
sim/lcd_checker.sv
sim/tb_lcd_top.sv

/* Bender.yml */
package:
  name: lcd_ctrl

sources:
  - files:
      - rtl/lcd_pkg.sv
      - rtl/lcd_regs.sv
      - rtl/lcd_id.sv
      - rtl/lcd_bus.sv
      - rtl/lcd_top.sv
  - target: test
    files:
      - sim/lcd_checker.sv
      - sim/tb_lcd_top.sv
